// ==== dv/csr_tb_table.svh ====
// columns: name, priv, op, addr, wdata, trap, expected rdata, expected illegal
// rows run back to back, each one access cycle, state carries over

localparam int NUM_ROWS = 24;

localparam row_t ROWS [NUM_ROWS] = '{
        // reset values
        '{"rst_mstatus", PM, RS, csr_pkg::ADDR_MSTATUS, 32'h0, 1'b0, 32'h0000_1800, 1'b0},
        '{"rst_misa", PM, RS, csr_pkg::ADDR_MISA, 32'h0, 1'b0, csr_pkg::MISA_VALUE, 1'b0},
        '{"rst_mhartid", PM, RS, csr_pkg::ADDR_MHARTID, 32'h0, 1'b0, TB_HART_ID, 1'b0},
        '{"rst_mtvec", PM, RS, csr_pkg::ADDR_MTVEC, 32'h0, 1'b0, 32'h0, 1'b0},
        '{"rst_mepc", PM, RS, csr_pkg::ADDR_MEPC, 32'h0, 1'b0, 32'h0, 1'b0},
        '{"rst_mie", PM, RS, csr_pkg::ADDR_MIE, 32'h0, 1'b0, 32'h0, 1'b0},
        // all six ops on mscratch, old value comes back
        '{"mscr_rw", PM, RW, csr_pkg::ADDR_MSCRATCH, 32'h1234_5678, 1'b0, 32'h0, 1'b0},
        '{"mscr_rs", PM, RS, csr_pkg::ADDR_MSCRATCH, 32'h0000_00f0, 1'b0, 32'h1234_5678, 1'b0},
        '{"mscr_rc", PM, RC, csr_pkg::ADDR_MSCRATCH, 32'h1200_0008, 1'b0, 32'h1234_56f8, 1'b0},
        '{"mscr_rwi", PM, RWI, csr_pkg::ADDR_MSCRATCH, 32'h0000_0015, 1'b0, 32'h0034_56f0, 1'b0},
        '{"mscr_rsi", PM, RSI, csr_pkg::ADDR_MSCRATCH, 32'h0000_000a, 1'b0, 32'h0000_0015, 1'b0},
        '{"mscr_rci", PM, RCI, csr_pkg::ADDR_MSCRATCH, 32'h0000_0003, 1'b0, 32'h0000_001f, 1'b0},
        '{"mscr_rd", PM, RS, csr_pkg::ADDR_MSCRATCH, 32'h0, 1'b0, 32'h0000_001c, 1'b0},
        '{"mtvec_rw", PM, RW, csr_pkg::ADDR_MTVEC, 32'h8000_0100, 1'b0, 32'h0, 1'b0},
        '{"mtvec_rd", PM, RS, csr_pkg::ADDR_MTVEC, 32'h0, 1'b0, 32'h8000_0100, 1'b0},
        // only MIE, MPIE and MPP stick
        '{"mstat_ones", PM, RW, csr_pkg::ADDR_MSTATUS, 32'hffff_ffff, 1'b0, 32'h0000_1800, 1'b0},
        '{"mstat_mask", PM, RS, csr_pkg::ADDR_MSTATUS, 32'h0, 1'b0, 32'h0000_1888, 1'b0},
        '{"mstat_clr", PM, RC, csr_pkg::ADDR_MSTATUS, 32'h0000_0088, 1'b0, 32'h0000_1888, 1'b0},
        // illegal and trapped accesses leave mscratch alone
        '{"bad_addr", PM, RS, 12'h7c0, 32'h0000_0055, 1'b0, 32'h0, 1'b1},
        '{"user_mscr", PU, RW, csr_pkg::ADDR_MSCRATCH, 32'h0000_dead, 1'b0, 32'h0000_001c, 1'b1},
        '{"trap_mscr", PM, RW, csr_pkg::ADDR_MSCRATCH, 32'h0000_beef, 1'b1, 32'h0000_001c, 1'b0},
        '{"mscr_kept", PM, RS, csr_pkg::ADDR_MSCRATCH, 32'h0, 1'b0, 32'h0000_001c, 1'b0},
        '{"mepc_rw", PM, RW, csr_pkg::ADDR_MEPC, 32'h0000_2004, 1'b0, 32'h0, 1'b0},
        '{"mepc_rd", PM, RS, csr_pkg::ADDR_MEPC, 32'h0, 1'b0, 32'h0000_2004, 1'b0}
    };

// ==== dv/csr_file_tb.sv ====
module csr_file_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int RAND_STEPS    = 32;
    localparam int RETIRE_CYCLES = 20;
    localparam csr_pkg::csr_data_t CYCLE_GAP  = 32'd13;
    localparam csr_pkg::csr_data_t TB_HART_ID = 32'd5;

    // short names for the table
    localparam csr_pkg::priv_t   PM  = csr_pkg::PRIV_M;
    localparam csr_pkg::priv_t   PU  = csr_pkg::PRIV_U;
    localparam csr_pkg::csr_op_t RW  = csr_pkg::OP_CSRRW;
    localparam csr_pkg::csr_op_t RS  = csr_pkg::OP_CSRRS;
    localparam csr_pkg::csr_op_t RC  = csr_pkg::OP_CSRRC;
    localparam csr_pkg::csr_op_t RWI = csr_pkg::OP_CSRRWI;
    localparam csr_pkg::csr_op_t RSI = csr_pkg::OP_CSRRSI;
    localparam csr_pkg::csr_op_t RCI = csr_pkg::OP_CSRRCI;
    // register ops first, immediate forms from index 3
    localparam csr_pkg::csr_op_t RAND_OPS [6] = '{RW, RS, RC, RWI, RSI, RCI};

    typedef struct packed {
        logic [95:0]        name;
        csr_pkg::priv_t     priv;
        csr_pkg::csr_op_t   op;
        csr_pkg::csr_addr_t addr;
        csr_pkg::csr_data_t wdata;
        logic               trap;
        csr_pkg::csr_data_t rdata;
        logic               illegal;
    } row_t;

    `include "csr_tb_table.svh"

    logic               CLK;
    logic               rst_n;
    csr_pkg::priv_t     priv;
    logic               csr_en;
    csr_pkg::csr_op_t   csr_op;
    csr_pkg::csr_addr_t csr_addr;
    csr_pkg::csr_data_t csr_wdata;
    logic               trap;
    logic               instr_retire;
    logic               meip;
    logic               mtip;
    logic               msip;
    csr_pkg::csr_data_t csr_rdata;
    logic               csr_illegal;
    logic               irq_pending;
    csr_pkg::cause_t    irq_code;
    csr_pkg::csr_data_t trap_vector;
    csr_pkg::csr_data_t epc;

    int                 errors;
    int                 checks;
    // shadow of the interrupt enables
    csr_pkg::csr_data_t sh_mie;
    logic               sh_gie;

    csr_file_top #(
        .HART_ID (TB_HART_ID)
    ) csr_file_top_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .priv         (priv),
        .csr_en       (csr_en),
        .csr_op       (csr_op),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .trap         (trap),
        .instr_retire (instr_retire),
        .meip         (meip),
        .mtip         (mtip),
        .msip         (msip),
        .csr_rdata    (csr_rdata),
        .csr_illegal  (csr_illegal),
        .irq_pending  (irq_pending),
        .irq_code     (irq_code),
        .trap_vector  (trap_vector),
        .epc          (epc)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input csr_pkg::csr_data_t exp,
        input csr_pkg::csr_data_t got);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    // one access cycle, sampled 2 ns before the next rising edge
    task automatic drive_access(input csr_pkg::priv_t p, input csr_pkg::csr_op_t op,
        input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t d, input logic t);
        @(negedge CLK);
        priv      = p;
        csr_en    = 1'b1;
        csr_op    = op;
        csr_addr  = a;
        csr_wdata = d;
        trap      = t;
        #2;
    endtask

    // csr_en low, rd_data still follows addr and nothing is written back
    task automatic read_quiet(input csr_pkg::csr_addr_t a);
        @(negedge CLK);
        csr_en   = 1'b0;
        trap     = 1'b0;
        csr_addr = a;
        #2;
    endtask

    // write, set or clear as the op code says
    function automatic csr_pkg::csr_data_t rmw_result(input csr_pkg::csr_op_t op,
        input csr_pkg::csr_data_t old, input csr_pkg::csr_data_t operand);
        if (op == RS || op == RSI)
            return old | operand;
        if (op == RC || op == RCI)
            return old & ~operand;
        return operand;
    endfunction

    // expected cause, 0 when nothing is pending
    function automatic csr_pkg::cause_t irq_expect(input csr_pkg::priv_t p, input logic e,
        input logic t, input logic s, input csr_pkg::csr_data_t en, input logic gie);
        if (!(p < csr_pkg::PRIV_M || gie))
            return '0;
        if (e && en[csr_pkg::IRQ_MEI_BIT])
            return csr_pkg::CAUSE_MEI;
        if (s && en[csr_pkg::IRQ_MSI_BIT])
            return csr_pkg::CAUSE_MSI;
        if (t && en[csr_pkg::IRQ_MTI_BIT])
            return csr_pkg::CAUSE_MTI;
        return '0;
    endfunction

    // pins and priv set here, enables written on the edge before
    // registered request must show both after one rising edge
    task automatic check_irq(input string name, input csr_pkg::priv_t p, input logic e,
        input logic t, input logic s);
        csr_pkg::cause_t exp_code;
        @(negedge CLK);
        csr_en = 1'b0;
        priv   = p;
        meip   = e;
        mtip   = t;
        msip   = s;
        @(negedge CLK);
        #2;
        exp_code = irq_expect(priv, meip, mtip, msip, sh_mie, sh_gie);
        check_value({name, " pending"}, {31'd0, exp_code != '0}, {31'd0, irq_pending});
        check_value({name, " code"}, {1'b0, exp_code}, {1'b0, irq_code});
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        csr_pkg::csr_data_t sh_scratch;
        csr_pkg::csr_data_t sh_mtvec;
        csr_pkg::csr_data_t operand;
        csr_pkg::csr_data_t base;
        csr_pkg::csr_data_t pulses;
        logic [31:0]        rnd;
        int unsigned        idx;
        void'($urandom(32'h181aace0));
        errors       = 0;
        checks       = 0;
        CLK          = 1'b0;
        rst_n        = 1'b0;
        priv         = PM;
        csr_en       = 1'b0;
        csr_op       = RS;
        csr_addr     = '0;
        csr_wdata    = '0;
        trap         = 1'b0;
        instr_retire = 1'b0;
        meip         = 1'b0;
        mtip         = 1'b0;
        msip         = 1'b0;
        repeat (RESET_CYCLES) @(negedge CLK);
        rst_n = 1'b1;
        #2;
        check_value("rst_trap_vector", 32'h0, trap_vector);
        check_value("rst_epc", 32'h0, epc);
        check_value("rst_irq_pending", 32'h0, {31'd0, irq_pending});

        // directed table
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            drive_access(ROWS[i].priv, ROWS[i].op, ROWS[i].addr, ROWS[i].wdata, ROWS[i].trap);
            check_value($sformatf("%0s", ROWS[i].name), ROWS[i].rdata, csr_rdata);
            check_value($sformatf("%0s illegal", ROWS[i].name), {31'd0, ROWS[i].illegal},
                {31'd0, csr_illegal});
        end
        read_quiet(csr_pkg::ADDR_MTVEC);
        check_value("trap_vector", 32'h8000_0100, trap_vector);
        check_value("epc", 32'h0000_2004, epc);

        // random operands, shadow starts from the table's end state
        sh_scratch = 32'h0000_001c;
        sh_mtvec   = 32'h8000_0100;
        for (int i = 0; i < RAND_STEPS; i++)
        begin
            rnd     = $urandom();
            idx     = $urandom_range(5, 0);
            operand = $urandom();
            // immediate forms carry a zero-extended 5 bit value
            if (idx >= 3)
                operand = operand & 32'h0000_001f;
            if (rnd[0])
            begin
                drive_access(PM, RAND_OPS[idx], csr_pkg::ADDR_MTVEC, operand, 1'b0);
                check_value("rand_mtvec", sh_mtvec, csr_rdata);
                sh_mtvec = rmw_result(RAND_OPS[idx], sh_mtvec, operand);
            end
            else
            begin
                drive_access(PM, RAND_OPS[idx], csr_pkg::ADDR_MSCRATCH, operand, 1'b0);
                check_value("rand_mscratch", sh_scratch, csr_rdata);
                sh_scratch = rmw_result(RAND_OPS[idx], sh_scratch, operand);
            end
        end
        read_quiet(csr_pkg::ADDR_MSCRATCH);
        check_value("rand_mscratch_final", sh_scratch, csr_rdata);
        check_value("rand_trap_vector", sh_mtvec, trap_vector);

        ////////////////////////////////////////////////////////////
        // counters
        ////////////////////////////////////////////////////////////

        read_quiet(csr_pkg::ADDR_MINSTRET);
        base   = csr_rdata;
        pulses = '0;
        for (int i = 0; i < RETIRE_CYCLES; i++)
        begin
            @(negedge CLK);
            rnd          = $urandom();
            instr_retire = rnd[0];
            if (rnd[0])
                pulses++;
        end
        read_quiet(csr_pkg::ADDR_MINSTRET);
        instr_retire = 1'b0;
        check_value("minstret_pulses", base + pulses, csr_rdata);

        read_quiet(csr_pkg::ADDR_MCYCLE);
        base = csr_rdata;
        repeat (CYCLE_GAP - 1) @(negedge CLK);
        read_quiet(csr_pkg::ADDR_MCYCLE);
        check_value("mcycle_gap", CYCLE_GAP, csr_rdata - base);
        // written value lands, then counts on
        drive_access(PM, RW, csr_pkg::ADDR_MCYCLE, 32'h0001_0000, 1'b0);
        read_quiet(csr_pkg::ADDR_MCYCLE);
        check_value("mcycle_written", 32'h0001_0000, csr_rdata);
        read_quiet(csr_pkg::ADDR_MCYCLE);
        check_value("mcycle_plus_one", 32'h0001_0001, csr_rdata);

        ////////////////////////////////////////////////////////////
        // interrupts
        ////////////////////////////////////////////////////////////

        sh_mie = 32'd1 << csr_pkg::IRQ_MTI_BIT;
        sh_gie = 1'b1;
        drive_access(PM, RW, csr_pkg::ADDR_MIE, sh_mie, 1'b0);
        drive_access(PM, RW, csr_pkg::ADDR_MSTATUS, 32'h0000_1808, 1'b0);
        check_irq("irq_mti", PM, 1'b0, 1'b1, 1'b0);
        sh_mie = 32'h0000_0888;
        drive_access(PM, RW, csr_pkg::ADDR_MIE, sh_mie, 1'b0);
        check_irq("irq_all_pins", PM, 1'b1, 1'b1, 1'b1);
        // global enable off at M
        sh_gie = 1'b0;
        drive_access(PM, RC, csr_pkg::ADDR_MSTATUS, 32'd1 << csr_pkg::MSTATUS_MIE_BIT, 1'b0);
        check_irq("irq_mie_off", PM, 1'b1, 1'b1, 1'b1);
        check_irq("irq_user_mode", PU, 1'b1, 1'b1, 1'b1);

        @(negedge CLK);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog, table rows plus a fixed margin for the other sections
    initial
    begin
        #((NUM_ROWS + 200) * CLK_PERIOD);
        $display("timeout: tests did not complete within %0d clock cycles", NUM_ROWS + 200);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== hdl/csr_access_decode.sv ====
module csr_access_decode (
    input  logic               csr_en,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::csr_data_t csr_wdata,
    input  csr_pkg::priv_t     priv,
    input  logic               trap,
    output logic               illegal,
    csr_access_if.decode       acc
);

    csr_pkg::csr_data_t rmw_data;
    logic               priv_low;

    ////////////////////////////////////////////////////////////
    // legality
    ////////////////////////////////////////////////////////////

    // bank decodes the address, answers hit and old value
    assign acc.addr = csr_addr;

    // addr[9:8] holds the lowest privilege allowed
    assign priv_low = priv < csr_addr[9:8];

    // unmapped or too privileged, only when enabled
    assign illegal = csr_en & (~acc.hit | priv_low);

    ////////////////////////////////////////////////////////////
    // read-modify-write
    ////////////////////////////////////////////////////////////

    // immediate forms arrive already zero-extended
    always_comb
    begin
        case (csr_op)
            csr_pkg::OP_CSRRW,
            csr_pkg::OP_CSRRWI:
                rmw_data = csr_wdata;
            // set bits on top of old value
            csr_pkg::OP_CSRRS,
            csr_pkg::OP_CSRRSI:
                rmw_data = acc.rd_data | csr_wdata;
            // clear bits from old value
            csr_pkg::OP_CSRRC,
            csr_pkg::OP_CSRRCI:
                rmw_data = acc.rd_data & ~csr_wdata;
            default:
                rmw_data = csr_wdata;
        endcase
    end

    assign acc.wr_data = rmw_data;

    // no store while the core takes a trap
    assign acc.wr_en = csr_en & ~illegal & ~trap;

endmodule

// ==== hdl/csr_access_if.sv ====
interface csr_access_if;

    // one access per cycle, decoder to bank
    csr_pkg::csr_addr_t addr;
    logic               wr_en;
    csr_pkg::csr_data_t wr_data;

    // answer from the bank in the same cycle
    csr_pkg::csr_data_t rd_data;
    logic               hit;

    // decoder side
    modport decode (
        output addr,
        output wr_en,
        output wr_data,
        input  rd_data,
        input  hit
    );

    // register bank side
    modport bank (
        input  addr,
        input  wr_en,
        input  wr_data,
        output rd_data,
        output hit
    );

endinterface

// ==== hdl/csr_file_top.sv ====
module csr_file_top #(
    parameter csr_pkg::csr_data_t HART_ID = 32'd0
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  csr_pkg::priv_t     priv,
    input  logic               csr_en,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::csr_data_t csr_wdata,
    input  logic               trap,
    input  logic               instr_retire,
    input  logic               meip,
    input  logic               mtip,
    input  logic               msip,
    output csr_pkg::csr_data_t csr_rdata,
    output logic               csr_illegal,
    output logic               irq_pending,
    output csr_pkg::cause_t    irq_code,
    output csr_pkg::csr_data_t trap_vector,
    output csr_pkg::csr_data_t epc
);

    ////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////

    csr_access_if acc_if ();
    csr_irq_if    irq_if ();

    // legality and write value
    csr_access_decode u_decode (
        .csr_en    (csr_en),
        .csr_op    (csr_op),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .priv      (priv),
        .trap      (trap),
        .illegal   (csr_illegal),
        .acc       (acc_if.decode)
    );

    // storage, counters, read mux
    csr_machine_regs #(
        .HART_ID (HART_ID)
    ) u_regs (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .instr_retire (instr_retire),
        .meip         (meip),
        .mtip         (mtip),
        .msip         (msip),
        .acc          (acc_if.bank),
        .irq          (irq_if.bank),
        .trap_vector  (trap_vector),
        .epc          (epc)
    );

    // registered request to the core
    csr_irq_unit u_irq (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .priv        (priv),
        .meip        (meip),
        .mtip        (mtip),
        .msip        (msip),
        .irq         (irq_if.irq),
        .irq_pending (irq_pending),
        .irq_code    (irq_code)
    );

    // old value goes back to the core
    assign csr_rdata = acc_if.rd_data;

endmodule

// ==== hdl/csr_irq_if.sv ====
interface csr_irq_if;

    // enables from mie
    logic meie;
    logic mtie;
    logic msie;
    // global enable from mstatus
    logic mstatus_mie;

    modport bank (
        output meie,
        output mtie,
        output msie,
        output mstatus_mie
    );

    modport irq (
        input meie,
        input mtie,
        input msie,
        input mstatus_mie
    );

endinterface

// ==== hdl/csr_irq_unit.sv ====
module csr_irq_unit (
    input  logic            CLK,
    input  logic            rst_n,
    input  csr_pkg::priv_t  priv,
    input  logic            meip,
    input  logic            mtip,
    input  logic            msip,
    csr_irq_if.irq          irq,
    output logic            irq_pending,
    output csr_pkg::cause_t irq_code
);

    logic            mei_req;
    logic            mti_req;
    logic            msi_req;
    logic            global_en;
    logic            pending_d;
    csr_pkg::cause_t code_d;

    // mip and mie per source
    assign mei_req = meip & irq.meie;
    assign mti_req = mtip & irq.mtie;
    assign msi_req = msip & irq.msie;

    // below M the request is taken whatever MIE says
    assign global_en = (priv < csr_pkg::PRIV_M) | irq.mstatus_mie;
    assign pending_d = global_en & (mei_req | msi_req | mti_req);

    // external first, then software, then timer
    always_comb
    begin
        if (!pending_d)
            code_d = '0;
        else if (mei_req)
            code_d = csr_pkg::CAUSE_MEI;
        else if (msi_req)
            code_d = csr_pkg::CAUSE_MSI;
        else
            code_d = csr_pkg::CAUSE_MTI;
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            irq_pending <= 1'b0;
            irq_code    <= '0;
        end
        else
        begin
            irq_pending <= pending_d;
            irq_code    <= code_d;
        end
    end

endmodule

// ==== hdl/csr_machine_regs.sv ====
module csr_machine_regs #(
    parameter csr_pkg::csr_data_t HART_ID = 32'd0
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               instr_retire,
    input  logic               meip,
    input  logic               mtip,
    input  logic               msip,
    csr_access_if.bank         acc,
    csr_irq_if.bank            irq,
    output csr_pkg::csr_data_t trap_vector,
    output csr_pkg::csr_data_t epc
);

    // mstatus, only the machine fields
    logic               mstatus_mie_q;
    logic               mstatus_mpie_q;
    csr_pkg::priv_t     mstatus_mpp_q;
    // mie enables
    logic               meie_q;
    logic               mtie_q;
    logic               msie_q;
    // full word registers
    csr_pkg::csr_data_t mtvec_q;
    csr_pkg::csr_data_t mscratch_q;
    csr_pkg::csr_data_t mepc_q;
    csr_pkg::csr_data_t mcause_q;
    csr_pkg::csr_data_t mtval_q;
    // live counters
    logic [63:0]        cycle_q;
    logic [63:0]        instret_q;
    // assembled read views
    csr_pkg::csr_data_t mstatus_rd;
    csr_pkg::csr_data_t mie_rd;
    csr_pkg::csr_data_t mip_rd;

    ////////////////////////////////////////////////////////////
    // register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            // core starts in M, interrupts off
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mstatus_mpp_q  <= csr_pkg::PRIV_M;
            meie_q         <= 1'b0;
            mtie_q         <= 1'b0;
            msie_q         <= 1'b0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
        end
        else if (acc.wr_en)
        begin
            case (acc.addr)
                csr_pkg::ADDR_MSTATUS:
                begin
                    mstatus_mie_q  <= acc.wr_data[csr_pkg::MSTATUS_MIE_BIT];
                    mstatus_mpie_q <= acc.wr_data[csr_pkg::MSTATUS_MPIE_BIT];
                    mstatus_mpp_q  <= acc.wr_data[csr_pkg::MSTATUS_MPP_LSB +: 2];
                end
                csr_pkg::ADDR_MIE:
                begin
                    meie_q <= acc.wr_data[csr_pkg::IRQ_MEI_BIT];
                    mtie_q <= acc.wr_data[csr_pkg::IRQ_MTI_BIT];
                    msie_q <= acc.wr_data[csr_pkg::IRQ_MSI_BIT];
                end
                csr_pkg::ADDR_MTVEC:    mtvec_q    <= acc.wr_data;
                csr_pkg::ADDR_MSCRATCH: mscratch_q <= acc.wr_data;
                csr_pkg::ADDR_MEPC:     mepc_q     <= acc.wr_data;
                csr_pkg::ADDR_MCAUSE:   mcause_q   <= acc.wr_data;
                csr_pkg::ADDR_MTVAL:    mtval_q    <= acc.wr_data;
                // mip and identity words are read only
                default:
                begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // counters, a word write wins over the increment
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
            cycle_q <= '0;
        else if (acc.wr_en && acc.addr == csr_pkg::ADDR_MCYCLE)
            cycle_q[31:0] <= acc.wr_data;
        else if (acc.wr_en && acc.addr == csr_pkg::ADDR_MCYCLEH)
            cycle_q[63:32] <= acc.wr_data;
        else
            cycle_q <= cycle_q + 64'd1;
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
            instret_q <= '0;
        else if (acc.wr_en && acc.addr == csr_pkg::ADDR_MINSTRET)
            instret_q[31:0] <= acc.wr_data;
        else if (acc.wr_en && acc.addr == csr_pkg::ADDR_MINSTRETH)
            instret_q[63:32] <= acc.wr_data;
        else if (instr_retire)
            instret_q <= instret_q + 64'd1;
    end

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        mstatus_rd = '0;
        mstatus_rd[csr_pkg::MSTATUS_MIE_BIT]       = mstatus_mie_q;
        mstatus_rd[csr_pkg::MSTATUS_MPIE_BIT]      = mstatus_mpie_q;
        mstatus_rd[csr_pkg::MSTATUS_MPP_LSB +: 2]  = mstatus_mpp_q;
        mie_rd = '0;
        mie_rd[csr_pkg::IRQ_MEI_BIT] = meie_q;
        mie_rd[csr_pkg::IRQ_MTI_BIT] = mtie_q;
        mie_rd[csr_pkg::IRQ_MSI_BIT] = msie_q;
        // pending bits come straight from the pins
        mip_rd = '0;
        mip_rd[csr_pkg::IRQ_MEI_BIT] = meip;
        mip_rd[csr_pkg::IRQ_MTI_BIT] = mtip;
        mip_rd[csr_pkg::IRQ_MSI_BIT] = msip;
    end

    always_comb
    begin
        acc.hit = 1'b1;
        case (acc.addr)
            csr_pkg::ADDR_MSTATUS:   acc.rd_data = mstatus_rd;
            csr_pkg::ADDR_MISA:      acc.rd_data = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MIE:       acc.rd_data = mie_rd;
            csr_pkg::ADDR_MTVEC:     acc.rd_data = mtvec_q;
            csr_pkg::ADDR_MSCRATCH:  acc.rd_data = mscratch_q;
            csr_pkg::ADDR_MEPC:      acc.rd_data = mepc_q;
            csr_pkg::ADDR_MCAUSE:    acc.rd_data = mcause_q;
            csr_pkg::ADDR_MTVAL:     acc.rd_data = mtval_q;
            csr_pkg::ADDR_MIP:       acc.rd_data = mip_rd;
            csr_pkg::ADDR_MCYCLE:    acc.rd_data = cycle_q[31:0];
            csr_pkg::ADDR_MCYCLEH:   acc.rd_data = cycle_q[63:32];
            csr_pkg::ADDR_MINSTRET:  acc.rd_data = instret_q[31:0];
            csr_pkg::ADDR_MINSTRETH: acc.rd_data = instret_q[63:32];
            csr_pkg::ADDR_MVENDORID: acc.rd_data = csr_pkg::VENDOR_ID;
            csr_pkg::ADDR_MARCHID:   acc.rd_data = csr_pkg::ARCH_ID;
            csr_pkg::ADDR_MIMPID:    acc.rd_data = csr_pkg::IMP_ID;
            csr_pkg::ADDR_MHARTID:   acc.rd_data = HART_ID;
            // unmapped, decoder flags it
            default:
            begin
                acc.rd_data = '0;
                acc.hit     = 1'b0;
            end
        endcase
    end

    // enable state for the interrupt unit
    assign irq.meie        = meie_q;
    assign irq.mtie        = mtie_q;
    assign irq.msie        = msie_q;
    assign irq.mstatus_mie = mstatus_mie_q;

    assign trap_vector = mtvec_q;
    assign epc         = mepc_q;

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [2:0]  csr_op_t;
    typedef logic [1:0]  priv_t;
    typedef logic [30:0] cause_t;

    // funct3 of the system opcode
    localparam csr_op_t OP_CSRRW  = 3'b001;
    localparam csr_op_t OP_CSRRS  = 3'b010;
    localparam csr_op_t OP_CSRRC  = 3'b011;
    localparam csr_op_t OP_CSRRWI = 3'b101;
    localparam csr_op_t OP_CSRRSI = 3'b110;
    localparam csr_op_t OP_CSRRCI = 3'b111;

    // privilege levels, H left out
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

    ////////////////////////////////////////////////////////////
    // machine address map
    ////////////////////////////////////////////////////////////

    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    // mstatus fields kept
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LSB  = 11;

    // same positions in mie and mip
    localparam int unsigned IRQ_MSI_BIT = 3;
    localparam int unsigned IRQ_MTI_BIT = 7;
    localparam int unsigned IRQ_MEI_BIT = 11;

    localparam cause_t CAUSE_MSI = 31'd3;
    localparam cause_t CAUSE_MTI = 31'd7;
    localparam cause_t CAUSE_MEI = 31'd11;

    // mxl = 32 bit, extensions I and M
    localparam csr_data_t MISA_VALUE = 32'h4000_1100;
    localparam csr_data_t VENDOR_ID  = 32'h0000_0000;
    localparam csr_data_t ARCH_ID    = 32'h0000_0000;
    localparam csr_data_t IMP_ID     = 32'h0000_0000;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the CSR file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module csr_file_tb -o csr_sim \
    && ./obj_dir/csr_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }

// ==== src.f ====
+incdir+dv
hdl/csr_pkg.sv
hdl/csr_access_if.sv
hdl/csr_irq_if.sv
hdl/csr_access_decode.sv
hdl/csr_machine_regs.sv
hdl/csr_irq_unit.sv
hdl/csr_file_top.sv
dv/csr_file_tb.sv
